/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_icache
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
common/icache_geom_pkg.sv
common/icache_l2_pkg.sv
logic/bram_1r1w.sv
icache/icache_lookup.sv
icache/icache_miss_reg.sv
icache/icache_plru.sv
icache/icache.sv
test/tb_clock.sv
test/tb_icache.sv

/* common/icache_geom_pkg.sv */
package icache_geom_pkg;

    // ------------------------------------------------------------------------
    // cache geometry

    localparam int ICACHE_NUM_SETS = 128;
    localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS);
    localparam int ICACHE_ASSOC = 2;
    localparam int ICACHE_TAG_WIDTH = 22;

    // two 16-byte fetch slots per 32-byte block
    localparam int ICACHE_FETCH_BYTES = 16;
    localparam int ICACHE_FETCH_SLOTS = 2;
    localparam int ICACHE_FETCH_OFFSET_WIDTH = $clog2(ICACHE_FETCH_SLOTS);

    // valid bit, pad bit and tag, rounded up to whole bytes
    localparam int ICACHE_TAG_ENTRY_BYTES = (ICACHE_TAG_WIDTH + 1 + 7) / 8;

    // ------------------------------------------------------------------------
    // types

    typedef logic [ICACHE_INDEX_WIDTH-1:0] icache_index_t;
    typedef logic [ICACHE_TAG_WIDTH-1:0] icache_tag_t;
    typedef logic [ICACHE_FETCH_OFFSET_WIDTH-1:0] icache_fetch_off_t;
    typedef logic [$clog2(ICACHE_ASSOC)-1:0] icache_way_t;
    typedef logic [ICACHE_FETCH_BYTES*8-1:0] icache_fetch_data_t;

    // valid in the top bit, then padding, then the tag
    typedef logic [ICACHE_TAG_ENTRY_BYTES*8-1:0] icache_tag_entry_t;

endpackage

/* common/icache_l2_pkg.sv */
package icache_l2_pkg;

    // block address is tag in the upper bits, set index in the lower bits
    localparam int L1_BLOCK_ADDR_WIDTH = 29;

    // a whole 32-byte block in one beat
    localparam int L1_BLOCK_DATA_WIDTH = 256;

    typedef logic [L1_BLOCK_ADDR_WIDTH-1:0] l1_block_addr_t;
    typedef logic [L1_BLOCK_DATA_WIDTH-1:0] l1_block_data_t;

endpackage

/* icache/icache.sv */
`timescale 1ns/1ps

module icache
    import icache_geom_pkg::*;
    import icache_l2_pkg::*;
(
    input  logic                                  CLK,
    input  logic                                  nRST,
    // core request
    input  logic                                  core_req_valid,
    input  icache_fetch_off_t                     core_req_fetch_off,
    input  icache_index_t                         core_req_index,
    // core response, one cycle after the request
    output logic [ICACHE_ASSOC-1:0]               core_resp_valid_by_way,
    output icache_tag_t [ICACHE_ASSOC-1:0]        core_resp_tag_by_way,
    output icache_fetch_data_t [ICACHE_ASSOC-1:0] core_resp_instr_by_way,
    // core feedback in the response cycle
    input  logic                                  core_resp_hit_valid,
    input  icache_way_t                           core_resp_hit_way,
    input  logic                                  core_resp_miss_valid,
    input  icache_tag_t                           core_resp_miss_tag,
    // L2 request
    output logic                                  l2_req_valid,
    output l1_block_addr_t                        l2_req_addr,
    input  logic                                  l2_req_ready,
    // L2 response
    input  logic                                  l2_resp_valid,
    input  l1_block_addr_t                        l2_resp_addr,
    input  l1_block_data_t                        l2_resp_data
);

    logic                                                   tag_ren;
    icache_index_t                                          tag_rindex;
    logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES*8-1:0]       tag_rdata;
    logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES-1:0]         tag_wen_byte;
    icache_index_t                                          tag_windex;
    logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES*8-1:0]       tag_wdata;

    logic                                                   data_ren;
    logic [ICACHE_INDEX_WIDTH+ICACHE_FETCH_OFFSET_WIDTH-1:0] data_rindex;
    logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES*8-1:0]           data_rdata;
    logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES-1:0]             data_wen_byte;
    logic [ICACHE_INDEX_WIDTH+ICACHE_FETCH_OFFSET_WIDTH-1:0] data_windex;
    logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES*8-1:0]           data_wdata;

    logic                                                   rsp_valid;
    icache_index_t                                          rsp_index;
    icache_fetch_off_t                                      rsp_fetch_off;
    icache_way_t                                            victim_way;

    logic                                                   fill_active;
    icache_index_t                                          fill_index;
    icache_tag_t                                            fill_tag;
    icache_way_t                                            fill_way;
    icache_fetch_data_t [ICACHE_FETCH_SLOTS-1:0]            fill_buffer;

    // ------------------------------------------------------------------------
    // pipeline and control

    icache_lookup u_lookup (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_fetch_off(core_req_fetch_off),
        .core_req_index(core_req_index),
        .tag_ren(tag_ren),
        .tag_rindex(tag_rindex),
        .tag_rdata(tag_rdata),
        .data_ren(data_ren),
        .data_rindex(data_rindex),
        .data_rdata(data_rdata),
        .fill_active(fill_active),
        .fill_index(fill_index),
        .fill_tag(fill_tag),
        .fill_way(fill_way),
        .fill_buffer(fill_buffer),
        .rsp_valid(rsp_valid),
        .rsp_index(rsp_index),
        .rsp_fetch_off(rsp_fetch_off),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way)
    );

    icache_plru u_plru (
        .CLK(CLK),
        .nRST(nRST),
        .rsp_index(rsp_index),
        .core_resp_hit_valid(core_resp_hit_valid),
        .core_resp_hit_way(core_resp_hit_way),
        .victim_way(victim_way)
    );

    icache_miss_reg u_miss_reg (
        .CLK(CLK),
        .nRST(nRST),
        .rsp_valid(rsp_valid),
        .rsp_index(rsp_index),
        .rsp_fetch_off(rsp_fetch_off),
        .victim_way(victim_way),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag(core_resp_miss_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(l2_req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data),
        .tag_wen_byte(tag_wen_byte),
        .tag_windex(tag_windex),
        .tag_wdata(tag_wdata),
        .data_wen_byte(data_wen_byte),
        .data_windex(data_windex),
        .data_wdata(data_wdata),
        .fill_active(fill_active),
        .fill_index(fill_index),
        .fill_tag(fill_tag),
        .fill_way(fill_way),
        .fill_buffer(fill_buffer)
    );

    // ------------------------------------------------------------------------
    // arrays, both ways side by side in each entry

    bram_1r1w #(
        .WIDTH_BYTES(ICACHE_ASSOC * ICACHE_TAG_ENTRY_BYTES),
        .DEPTH(ICACHE_NUM_SETS)
    ) u_tag_array (
        .CLK(CLK),
        .nRST(nRST),
        .ren(tag_ren),
        .rindex(tag_rindex),
        .rdata(tag_rdata),
        .wen_byte(tag_wen_byte),
        .windex(tag_windex),
        .wdata(tag_wdata)
    );

    bram_1r1w #(
        .WIDTH_BYTES(ICACHE_ASSOC * ICACHE_FETCH_BYTES),
        .DEPTH(ICACHE_NUM_SETS * ICACHE_FETCH_SLOTS)
    ) u_data_array (
        .CLK(CLK),
        .nRST(nRST),
        .ren(data_ren),
        .rindex(data_rindex),
        .rdata(data_rdata),
        .wen_byte(data_wen_byte),
        .windex(data_windex),
        .wdata(data_wdata)
    );

endmodule

/* icache/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup import icache_geom_pkg::*; (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic                                                core_req_valid,
    input  icache_fetch_off_t                                   core_req_fetch_off,
    input  icache_index_t                                       core_req_index,
    output logic                                                tag_ren,
    output icache_index_t                                       tag_rindex,
    input  logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES*8-1:0]    tag_rdata,
    output logic                                                data_ren,
    output logic [ICACHE_INDEX_WIDTH+ICACHE_FETCH_OFFSET_WIDTH-1:0] data_rindex,
    input  logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES*8-1:0]        data_rdata,
    input  logic                                                fill_active,
    input  icache_index_t                                       fill_index,
    input  icache_tag_t                                         fill_tag,
    input  icache_way_t                                         fill_way,
    input  icache_fetch_data_t [ICACHE_FETCH_SLOTS-1:0]         fill_buffer,
    output logic                                                rsp_valid,
    output icache_index_t                                       rsp_index,
    output icache_fetch_off_t                                   rsp_fetch_off,
    output logic [ICACHE_ASSOC-1:0]                             core_resp_valid_by_way,
    output icache_tag_t [ICACHE_ASSOC-1:0]                      core_resp_tag_by_way,
    output icache_fetch_data_t [ICACHE_ASSOC-1:0]               core_resp_instr_by_way
);

    icache_tag_entry_t [ICACHE_ASSOC-1:0]  tag_entries;
    icache_fetch_data_t [ICACHE_ASSOC-1:0] way_data;
    logic                                  bypass;

    // ------------------------------------------------------------------------
    // request stage, both arrays read in parallel

    assign tag_ren = core_req_valid;
    assign tag_rindex = core_req_index;
    assign data_ren = core_req_valid;
    assign data_rindex = {core_req_index, core_req_fetch_off};

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= core_req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        rsp_index <= core_req_index;
        rsp_fetch_off <= core_req_fetch_off;
    end

    // ------------------------------------------------------------------------
    // response stage

    assign tag_entries = tag_rdata;
    assign way_data = data_rdata;

    // refill in flight for this set, so the array may still be stale
    assign bypass = rsp_valid && fill_active && rsp_index == fill_index;

    always_comb begin
        for (int w = 0; w < ICACHE_ASSOC; w++) begin
            core_resp_valid_by_way[w] = tag_entries[w][$bits(icache_tag_entry_t)-1];
            core_resp_tag_by_way[w] = tag_entries[w][ICACHE_TAG_WIDTH-1:0];
            core_resp_instr_by_way[w] = way_data[w];
        end
        // new block shows up in the way it is filling
        if (bypass) begin
            core_resp_valid_by_way[fill_way] = 1'b1;
            core_resp_tag_by_way[fill_way] = fill_tag;
            core_resp_instr_by_way[fill_way] = fill_buffer[rsp_fetch_off];
        end
    end

endmodule

/* icache/icache_miss_reg.sv */
`timescale 1ns/1ps

module icache_miss_reg
    import icache_geom_pkg::*;
    import icache_l2_pkg::*;
(
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic                                                rsp_valid,
    input  icache_index_t                                       rsp_index,
    input  icache_fetch_off_t                                   rsp_fetch_off,
    input  icache_way_t                                         victim_way,
    input  logic                                                core_resp_miss_valid,
    input  icache_tag_t                                         core_resp_miss_tag,
    output logic                                                l2_req_valid,
    output l1_block_addr_t                                      l2_req_addr,
    input  logic                                                l2_req_ready,
    input  logic                                                l2_resp_valid,
    input  l1_block_addr_t                                      l2_resp_addr,
    input  l1_block_data_t                                      l2_resp_data,
    output logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES-1:0]      tag_wen_byte,
    output icache_index_t                                       tag_windex,
    output logic [ICACHE_ASSOC*ICACHE_TAG_ENTRY_BYTES*8-1:0]    tag_wdata,
    output logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES-1:0]          data_wen_byte,
    output logic [ICACHE_INDEX_WIDTH+ICACHE_FETCH_OFFSET_WIDTH-1:0] data_windex,
    output logic [ICACHE_ASSOC*ICACHE_FETCH_BYTES*8-1:0]        data_wdata,
    output logic                                                fill_active,
    output icache_index_t                                       fill_index,
    output icache_tag_t                                         fill_tag,
    output icache_way_t                                         fill_way,
    output icache_fetch_data_t [ICACHE_FETCH_SLOTS-1:0]         fill_buffer
);

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        WAIT_DATA,
        FILL,
        DELAY
    } miss_state_t;

    miss_state_t       state;
    miss_state_t       state_next;
    icache_index_t     miss_index;
    icache_tag_t       miss_tag;
    icache_way_t       miss_way;
    icache_fetch_off_t fill_cnt;
    l1_block_data_t    block_buf;
    logic              miss_same;
    logic              miss_load;
    logic              take_resp;
    logic              last_slot;

    // ------------------------------------------------------------------------
    // miss register control

    // a repeat report of the held miss is dropped
    assign miss_same = state != IDLE && rsp_index == miss_index
        && core_resp_miss_tag == miss_tag;

    // pending request keeps its address until L2 takes it
    // and a refill in progress runs to its end
    assign miss_load = rsp_valid && core_resp_miss_valid && !miss_same
        && state != REQUEST && state != FILL;

    assign take_resp = state == WAIT_DATA && l2_resp_valid
        && l2_resp_addr == {miss_tag, miss_index};

    assign last_slot = fill_cnt == icache_fetch_off_t'(ICACHE_FETCH_SLOTS - 1);

    always_comb begin
        state_next = state;
        if (state == FILL) begin
            if (last_slot) begin
                state_next = DELAY;
            end
        end else if (miss_load) begin
            state_next = REQUEST;
        end else if (state == DELAY) begin
            state_next = IDLE;
        end else if (take_resp) begin
            state_next = FILL;
        end else if (state == REQUEST && l2_req_ready) begin
            state_next = WAIT_DATA;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            fill_cnt <= '0;
        end else begin
            state <= state_next;
            fill_cnt <= (state == FILL) ? fill_cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_load) begin
            miss_index <= rsp_index;
            miss_tag <= core_resp_miss_tag;
            miss_way <= victim_way;
        end
        if (take_resp) begin
            block_buf <= l2_resp_data;
        end
    end

    // ------------------------------------------------------------------------
    // L2 request and bypass view

    assign l2_req_valid = state == REQUEST;
    assign l2_req_addr = {miss_tag, miss_index};

    assign fill_active = state == FILL || state == DELAY;
    assign fill_index = miss_index;
    assign fill_tag = miss_tag;
    assign fill_way = miss_way;
    assign fill_buffer = block_buf;

    // ------------------------------------------------------------------------
    // array writes, victim way only

    always_comb begin
        tag_wen_byte = '0;
        data_wen_byte = '0;
        if (state == FILL) begin
            data_wen_byte[miss_way*ICACHE_FETCH_BYTES +: ICACHE_FETCH_BYTES] = '1;
            // tag goes valid with the last slot
            if (last_slot) begin
                tag_wen_byte[miss_way*ICACHE_TAG_ENTRY_BYTES +: ICACHE_TAG_ENTRY_BYTES] = '1;
            end
        end
    end

    assign tag_windex = miss_index;
    assign tag_wdata = {ICACHE_ASSOC{1'b1, 1'b0, miss_tag}};
    assign data_windex = {miss_index, fill_cnt};
    assign data_wdata = {ICACHE_ASSOC{fill_buffer[fill_cnt]}};

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_addr));

    a_write_in_fill: assert property (@(posedge CLK) disable iff (!nRST)
        ((|tag_wen_byte) || (|data_wen_byte)) |-> state == FILL);

    // core only reports a miss in a lookup response cycle
    a_miss_in_rsp: assert property (@(posedge CLK) disable iff (!nRST)
        core_resp_miss_valid |-> rsp_valid && !$isunknown({rsp_index, rsp_fetch_off}));

endmodule

/* icache/icache_plru.sv */
`timescale 1ns/1ps

module icache_plru import icache_geom_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  icache_index_t rsp_index,
    input  logic          core_resp_hit_valid,
    input  icache_way_t   core_resp_hit_way,
    output icache_way_t   victim_way
);

    // one bit per set names the least recently used way
    icache_way_t [ICACHE_NUM_SETS-1:0] lru_bits;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lru_bits <= '0;
        end else if (core_resp_hit_valid) begin
            // two ways, so the other way becomes LRU
            lru_bits[rsp_index] <= ~core_resp_hit_way;
        end
    end

    assign victim_way = lru_bits[rsp_index];

endmodule

/* logic/bram_1r1w.sv */
`timescale 1ns/1ps

module bram_1r1w #(
    parameter int WIDTH_BYTES = 4,
    parameter int DEPTH = 64
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] rindex,
    output logic [WIDTH_BYTES*8-1:0] rdata,
    input  logic [WIDTH_BYTES-1:0]   wen_byte,
    input  logic [$clog2(DEPTH)-1:0] windex,
    input  logic [WIDTH_BYTES*8-1:0] wdata
);

    logic [WIDTH_BYTES*8-1:0] mem [DEPTH];
    logic [WIDTH_BYTES*8-1:0] rd_next;

    // write-first: bytes written this cycle go straight to the read
    always_comb begin
        rd_next = mem[rindex];
        for (int b = 0; b < WIDTH_BYTES; b++) begin
            if (wen_byte[b] && windex == rindex) begin
                rd_next[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            for (int b = 0; b < WIDTH_BYTES; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            // rdata holds when no read is issued
            if (ren) begin
                rdata <= rd_next;
            end
        end
    end

    a_windex_known: assert property (@(posedge CLK) disable iff (!nRST)
        |wen_byte |-> !$isunknown(windex));

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    // 40 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) CLK = ~CLK;
        end
    end

    // reset held low for a fixed number of rising edges
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

/* test/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache
    import icache_geom_pkg::*;
    import icache_l2_pkg::*;
();

    localparam int SEED = 32'h2fe9_3198;
    localparam int WAIT_LIMIT = 200;

    logic CLK;
    logic nRST;
    logic core_req_valid;
    icache_fetch_off_t core_req_fetch_off;
    icache_index_t core_req_index;
    logic [ICACHE_ASSOC-1:0] core_resp_valid_by_way;
    icache_tag_t [ICACHE_ASSOC-1:0] core_resp_tag_by_way;
    icache_fetch_data_t [ICACHE_ASSOC-1:0] core_resp_instr_by_way;
    logic core_resp_hit_valid;
    icache_way_t core_resp_hit_way;
    logic core_resp_miss_valid;
    icache_tag_t core_resp_miss_tag;
    logic l2_req_valid;
    l1_block_addr_t l2_req_addr;
    logic l2_req_ready = 1'b0;
    logic l2_resp_valid;
    l1_block_addr_t l2_resp_addr;
    l1_block_data_t l2_resp_data;

    // expected response, valid for one cycle while chk_resp is high
    logic chk_resp;
    logic [ICACHE_ASSOC-1:0] exp_valid;
    icache_tag_t [ICACHE_ASSOC-1:0] exp_tag;
    icache_fetch_data_t [ICACHE_ASSOC-1:0] exp_instr;
    logic req_expected;
    l1_block_addr_t exp_req_addr;

    // shadow of the cache contents and LRU bits
    logic shadow_valid [ICACHE_NUM_SETS][ICACHE_ASSOC];
    icache_tag_t shadow_tag [ICACHE_NUM_SETS][ICACHE_ASSOC];
    l1_block_data_t shadow_data [ICACHE_NUM_SETS][ICACHE_ASSOC];
    icache_way_t shadow_lru [ICACHE_NUM_SETS];

    // the one outstanding miss as the core sees it
    logic pend_active;
    logic pend_acked;
    icache_index_t pend_index;
    icache_tag_t pend_tag;
    icache_way_t pend_way;

    int err_count = 0;
    int timeout_count = 0;
    int hs_count = 0;
    int ready_wait = 3;

    tb_clock u_clock (
        .CLK(CLK),
        .nRST(nRST)
    );

    icache u_icache (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_fetch_off(core_req_fetch_off),
        .core_req_index(core_req_index),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .core_resp_hit_valid(core_resp_hit_valid),
        .core_resp_hit_way(core_resp_hit_way),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag(core_resp_miss_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(l2_req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data)
    );

    task automatic count_mismatch(input string name, input logic [255:0] got,
                                  input logic [255:0] expected);
        err_count++;
        $display("FAILED %0t %s got %0h expected %0h", $time, name, got, expected);
    endtask

    task automatic count_failure(input string what);
        err_count++;
        $display("%0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------------------
    // checks

    a_reset_idle: assert property (@(posedge CLK) $rose(nRST) |-> !l2_req_valid)
        else count_mismatch("l2_req_valid", 256'($sampled(l2_req_valid)), 256'(0));

    a_resp_valid: assert property (@(posedge CLK) disable iff (!nRST)
        chk_resp |-> core_resp_valid_by_way == exp_valid)
        else count_mismatch("core_resp_valid_by_way",
            256'($sampled(core_resp_valid_by_way)), 256'($sampled(exp_valid)));

    for (genvar w = 0; w < ICACHE_ASSOC; w++) begin : g_way_check
        a_resp_tag: assert property (@(posedge CLK) disable iff (!nRST)
            chk_resp && exp_valid[w] |-> core_resp_tag_by_way[w] == exp_tag[w])
            else count_mismatch($sformatf("core_resp_tag_by_way[%0d]", w),
                256'($sampled(core_resp_tag_by_way[w])), 256'($sampled(exp_tag[w])));

        a_resp_instr: assert property (@(posedge CLK) disable iff (!nRST)
            chk_resp && exp_valid[w] |-> core_resp_instr_by_way[w] == exp_instr[w])
            else count_mismatch($sformatf("core_resp_instr_by_way[%0d]", w),
                256'($sampled(core_resp_instr_by_way[w])), 256'($sampled(exp_instr[w])));
    end

    a_req_expected: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid |-> req_expected)
        else count_mismatch("l2_req_valid", 256'(1), 256'(0));

    a_req_addr: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid |-> l2_req_addr == exp_req_addr)
        else count_mismatch("l2_req_addr", 256'($sampled(l2_req_addr)),
            256'($sampled(exp_req_addr)));

    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_addr))
        else count_failure("L2 request dropped or changed while l2_req_ready was low");

    a_no_repeat: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && l2_req_ready |=> !l2_req_valid)
        else count_mismatch("l2_req_valid", 256'(1), 256'(0));

    // ------------------------------------------------------------------------
    // L2 request side, ready after a random delay

    always @(posedge CLK) begin
        if (l2_req_valid && l2_req_ready) begin
            l2_req_ready <= 1'b0;
            hs_count <= hs_count + 1;
        end else if (l2_req_valid) begin
            if (ready_wait == 0) begin
                l2_req_ready <= 1'b1;
            end else begin
                ready_wait <= ready_wait - 1;
            end
        end else begin
            ready_wait <= $urandom_range(5, 1);
        end
    end

    function automatic l1_block_data_t random_block();
        l1_block_data_t blk;
        for (int i = 0; i < L1_BLOCK_DATA_WIDTH / 32; i++) begin
            blk[i*32 +: 32] = $urandom;
        end
        return blk;
    endfunction

    // one lookup, with hit or miss feedback in the response cycle
    task automatic lookup(input icache_index_t idx, input icache_fetch_off_t off,
                          input icache_tag_t tag);
        int hit_way;
        hit_way = -1;
        @(posedge CLK);
        core_req_valid <= 1'b1;
        core_req_index <= idx;
        core_req_fetch_off <= off;
        @(posedge CLK);
        core_req_valid <= 1'b0;
        chk_resp <= 1'b1;
        for (int w = 0; w < ICACHE_ASSOC; w++) begin
            exp_valid[w] <= shadow_valid[idx][w];
            exp_tag[w] <= shadow_tag[idx][w];
            exp_instr[w] <= shadow_data[idx][w][off*ICACHE_FETCH_BYTES*8 +: ICACHE_FETCH_BYTES*8];
            if (shadow_valid[idx][w] && shadow_tag[idx][w] == tag) begin
                hit_way = w;
            end
        end
        if (hit_way >= 0) begin
            core_resp_hit_valid <= 1'b1;
            core_resp_hit_way <= icache_way_t'(hit_way);
            shadow_lru[idx] = ~icache_way_t'(hit_way);
        end else begin
            core_resp_miss_valid <= 1'b1;
            core_resp_miss_tag <= tag;
            // a repeat of the held miss starts nothing new
            if (!(pend_active && pend_index == idx && pend_tag == tag)) begin
                pend_active = 1'b1;
                pend_acked = 1'b0;
                pend_index = idx;
                pend_tag = tag;
                pend_way = shadow_lru[idx];
                req_expected <= 1'b1;
                exp_req_addr <= {tag, idx};
            end
        end
        @(posedge CLK);
        chk_resp <= 1'b0;
        core_resp_hit_valid <= 1'b0;
        core_resp_miss_valid <= 1'b0;
    endtask

    task automatic scan_set(input icache_index_t idx, input icache_tag_t tag, input int count);
        for (int i = 0; i < count; i++) begin
            lookup(idx, icache_fetch_off_t'(i), tag);
        end
    endtask

    task automatic wait_handshake();
        int start;
        int n;
        start = hs_count;
        n = 0;
        while (hs_count == start && n < WAIT_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        if (hs_count == start) begin
            timeout_count++;
            $display("%0t: no L2 request handshake within %0d cycles", $time, WAIT_LIMIT);
        end else begin
            pend_acked = 1'b1;
            req_expected <= 1'b0;
        end
    endtask

    task automatic send_block(input l1_block_addr_t addr, input l1_block_data_t blk);
        @(posedge CLK);
        l2_resp_valid <= 1'b1;
        l2_resp_addr <= addr;
        l2_resp_data <= blk;
        // only the pending miss takes a block, once its request went out
        if (pend_active && pend_acked && addr == {pend_tag, pend_index}) begin
            shadow_valid[pend_index][pend_way] = 1'b1;
            shadow_tag[pend_index][pend_way] = pend_tag;
            shadow_data[pend_index][pend_way] = blk;
            pend_active = 1'b0;
        end
        @(posedge CLK);
        l2_resp_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // stimulus

    initial begin
        icache_index_t idx_a;
        icache_index_t idx_c;
        icache_index_t idx_d;
        icache_index_t idx_e;
        icache_tag_t tag_a;
        icache_tag_t tag_c;
        icache_tag_t tag_d;
        icache_tag_t tag_e;
        int n;
        void'($urandom(SEED));
        core_req_valid = 1'b0;
        core_req_fetch_off = '0;
        core_req_index = '0;
        core_resp_hit_valid = 1'b0;
        core_resp_hit_way = '0;
        core_resp_miss_valid = 1'b0;
        core_resp_miss_tag = '0;
        l2_resp_valid = 1'b0;
        l2_resp_addr = '0;
        l2_resp_data = '0;
        chk_resp = 1'b0;
        exp_valid = '0;
        exp_tag = '0;
        exp_instr = '0;
        req_expected = 1'b0;
        exp_req_addr = '0;
        pend_active = 1'b0;
        pend_acked = 1'b0;
        pend_index = '0;
        pend_tag = '0;
        pend_way = '0;
        for (int s = 0; s < ICACHE_NUM_SETS; s++) begin
            shadow_lru[s] = '0;
            for (int w = 0; w < ICACHE_ASSOC; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_tag[s][w] = '0;
                shadow_data[s][w] = '0;
            end
        end

        n = 0;
        while (!nRST && n < WAIT_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        if (!nRST) begin
            timeout_count++;
            $display("%0t: reset was never released", $time);
        end
        repeat (2) @(posedge CLK);

        idx_a = icache_index_t'($urandom);
        idx_c = idx_a + 7'd37;
        idx_d = idx_a + 7'd74;
        idx_e = idx_a + 7'd101;
        tag_a = icache_tag_t'($urandom);
        tag_c = icache_tag_t'($urandom);
        tag_d = icache_tag_t'($urandom);
        tag_e = icache_tag_t'($urandom);

        // cold miss, held request, then refill into way 0
        lookup(idx_a, 0, tag_a);
        wait_handshake();
        repeat (4) @(posedge CLK);
        // response lands in the first refill cycle, served from the miss buffer
        fork
            send_block({tag_a, idx_a}, random_block());
            lookup(idx_a, 1, tag_a);
        join
        scan_set(idx_a, tag_a, 8);

        // hits on way 0, so the next miss in this set goes to way 1
        lookup(idx_a, 1, ~tag_a);
        wait_handshake();
        send_block({~tag_a, idx_a}, random_block());
        scan_set(idx_a, ~tag_a, 4);
        scan_set(idx_a, tag_a, 4);

        // responses for other addresses are dropped
        lookup(idx_c, 0, tag_c);
        wait_handshake();
        send_block({tag_c ^ 22'h1, idx_c}, random_block());
        send_block({tag_c, idx_c ^ 7'h1}, random_block());
        scan_set(idx_c, tag_c, 2);
        send_block({tag_c, idx_c}, random_block());
        scan_set(idx_c, tag_c, 4);

        // a newer miss replaces one still waiting for data
        lookup(idx_d, 1, tag_d);
        wait_handshake();
        lookup(idx_e, 0, tag_e);
        wait_handshake();
        send_block({tag_d, idx_d}, random_block());
        send_block({tag_e, idx_e}, random_block());
        scan_set(idx_e, tag_e, 4);
        scan_set(idx_d, tag_d, 1);
        wait_handshake();
        send_block({tag_d, idx_d}, random_block());
        scan_set(idx_d, tag_d, 2);
        repeat (4) @(posedge CLK);

        $display("run complete: %0d check errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
